// ==== source/axi_sram_pkg.sv ====
package axi_sram_pkg;

    // SRAM window in the system memory map.
    localparam logic [31:0] SRAM_BASE  = 32'h8000_0000;
    localparam int          SRAM_WORDS = 1024;
    localparam int          SRAM_IDX_W = 10;  // Word index width.

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,   // Storage read in flight.
        READ_RESP,
        WRITE_RESP
    } slave_state_e;

    typedef enum logic [1:0] {
        NONE,
        FETCH_RD,
        DATA_RD,
        DATA_WR
    } grant_e;

    // Read address channel.
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;    // Single beat only, so always zero.
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        axi_resp_e  resp;
    } axi_b_t;

    // Read data channel.
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

endpackage

// ==== source/sram_byte_array.sv ====
`timescale 1ns/1ps

module sram_byte_array (
    input  logic                                clk,
    input  logic                                rd_en,
    input  logic                                wr_en,
    input  logic [axi_sram_pkg::SRAM_IDX_W-1:0] idx,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    output logic [31:0]                         rdata
);
    import axi_sram_pkg::*;

    logic [31:0] mem [SRAM_WORDS];

    initial begin
        for (int i = 0; i < SRAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte lanes without a strobe keep their old value.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[idx];  // Held until the next read.
        end
    end

endmodule

// ==== source/axi_sram_slave.sv ====
`timescale 1ns/1ps

module axi_sram_slave (
    input  logic                                clk,
    input  logic                                rst,
    input  axi_sram_pkg::axi_ar_t               slv_ar,
    input  logic                                slv_arvalid,
    output logic                                slv_arready,
    input  axi_sram_pkg::axi_aw_t               slv_aw,
    input  logic                                slv_awvalid,
    output logic                                slv_awready,
    input  axi_sram_pkg::axi_w_t                slv_w,
    input  logic                                slv_wvalid,
    output logic                                slv_wready,
    output axi_sram_pkg::axi_b_t                slv_b,
    output logic                                slv_bvalid,
    input  logic                                slv_bready,
    output axi_sram_pkg::axi_r_t                slv_r,
    output logic                                slv_rvalid,
    input  logic                                slv_rready,
    output logic                                mem_rd_en,
    output logic                                mem_wr_en,
    output logic [axi_sram_pkg::SRAM_IDX_W-1:0] mem_idx,
    output logic [31:0]                         mem_wdata,
    output logic [3:0]                          mem_wstrb,
    input  logic [31:0]                         mem_rdata
);
    import axi_sram_pkg::*;

    slave_state_e state;
    slave_state_e state_next;
    logic [31:0]  req_addr;
    logic [3:0]   req_id;
    logic         req_hit;
    logic         wr_hit;
    logic         ar_fire;
    logic         wr_fire;
    logic         r_fire;
    logic         b_fire;

    function automatic logic in_window(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - SRAM_BASE;  // Wraps for addresses below the base.
        return offset < SRAM_WORDS * 4;
    endfunction

    function automatic logic [SRAM_IDX_W-1:0] word_index(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - SRAM_BASE;
        return offset[SRAM_IDX_W+1:2];
    endfunction

    // Reads win over writes in IDLE.
    assign slv_arready = (state == IDLE);
    assign slv_awready = (state == IDLE) && !slv_arvalid && slv_awvalid && slv_wvalid;
    assign slv_wready  = slv_awready;  // AW and W go together.

    assign ar_fire = slv_arvalid && slv_arready;
    assign wr_fire = slv_awvalid && slv_awready && slv_wvalid && slv_wready;
    assign r_fire  = slv_rvalid && slv_rready;
    assign b_fire  = slv_bvalid && slv_bready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ar_fire) begin
                    state_next = READ_WAIT;
                end else if (wr_fire) begin
                    state_next = WRITE_RESP;  // Storage already written.
                end
            end
            READ_WAIT:  state_next = READ_RESP;
            READ_RESP: begin
                if (r_fire) begin
                    state_next = IDLE;
                end
            end
            WRITE_RESP: begin
                if (b_fire) begin
                    state_next = IDLE;
                end
            end
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request capture, kept until the response is taken.
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            req_addr <= slv_ar.addr;
            req_id   <= slv_ar.id;
        end else if (wr_fire) begin
            req_addr <= slv_aw.addr;
            req_id   <= slv_aw.id;
        end
    end

    assign req_hit = in_window(req_addr);
    assign wr_hit  = in_window(slv_aw.addr);

    // Storage side.
    assign mem_rd_en = (state == READ_WAIT) && req_hit;
    assign mem_wr_en = wr_fire && wr_hit;  // No write outside the window.
    assign mem_idx   = (state == IDLE) ? word_index(slv_aw.addr) : word_index(req_addr);
    assign mem_wdata = slv_w.data;
    assign mem_wstrb = slv_w.strb;

    // Single-beat read response. Storage output holds while stalled.
    assign slv_rvalid = (state == READ_RESP);

    always_comb begin
        slv_r.id   = req_id;
        slv_r.data = req_hit ? mem_rdata : '0;
        slv_r.resp = req_hit ? OKAY : DECERR;
        slv_r.last = 1'b1;
    end

    assign slv_bvalid = (state == WRITE_RESP);

    always_comb begin
        slv_b.id   = req_id;
        slv_b.resp = req_hit ? OKAY : DECERR;
    end

endmodule

// ==== source/axi_sram_arbiter.sv ====
`timescale 1ns/1ps

module axi_sram_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    // Instruction fetch port, read only.
    input  axi_sram_pkg::axi_ar_t fetch_ar,
    input  logic                  fetch_arvalid,
    output logic                  fetch_arready,
    output axi_sram_pkg::axi_r_t  fetch_r,
    output logic                  fetch_rvalid,
    input  logic                  fetch_rready,
    // Data port.
    input  axi_sram_pkg::axi_ar_t data_ar,
    input  logic                  data_arvalid,
    output logic                  data_arready,
    input  axi_sram_pkg::axi_aw_t data_aw,
    input  logic                  data_awvalid,
    output logic                  data_awready,
    input  axi_sram_pkg::axi_w_t  data_w,
    input  logic                  data_wvalid,
    output logic                  data_wready,
    output axi_sram_pkg::axi_b_t  data_b,
    output logic                  data_bvalid,
    input  logic                  data_bready,
    output axi_sram_pkg::axi_r_t  data_r,
    output logic                  data_rvalid,
    input  logic                  data_rready,
    // Toward the slave.
    output axi_sram_pkg::axi_ar_t slv_ar,
    output logic                  slv_arvalid,
    input  logic                  slv_arready,
    output axi_sram_pkg::axi_aw_t slv_aw,
    output logic                  slv_awvalid,
    input  logic                  slv_awready,
    output axi_sram_pkg::axi_w_t  slv_w,
    output logic                  slv_wvalid,
    input  logic                  slv_wready,
    input  axi_sram_pkg::axi_b_t  slv_b,
    input  logic                  slv_bvalid,
    output logic                  slv_bready,
    input  axi_sram_pkg::axi_r_t  slv_r,
    input  logic                  slv_rvalid,
    output logic                  slv_rready
);
    import axi_sram_pkg::*;

    grant_e grant_q;
    grant_e sel;
    logic   data_first_q;  // Data port goes first on the next tie.
    logic   data_req;
    logic   idle;
    logic   addr_fire;
    logic   resp_fire;

    assign idle     = (grant_q == NONE);
    assign data_req = data_arvalid || (data_awvalid && data_wvalid);

    // Round robin between ports, read before write inside the data port.
    always_comb begin
        sel = NONE;
        if (fetch_arvalid && (!data_req || !data_first_q)) begin
            sel = FETCH_RD;
        end else if (data_arvalid) begin
            sel = DATA_RD;
        end else if (data_awvalid && data_wvalid) begin
            sel = DATA_WR;
        end
    end

    // Address path is only open while no transaction is in flight.
    assign slv_ar      = (sel == FETCH_RD) ? fetch_ar : data_ar;
    assign slv_arvalid = idle && ((sel == FETCH_RD) || (sel == DATA_RD));
    assign slv_aw      = data_aw;
    assign slv_awvalid = idle && (sel == DATA_WR);
    assign slv_w       = data_w;
    assign slv_wvalid  = idle && (sel == DATA_WR);

    // Fetch also sees ready while nobody requests.
    assign fetch_arready = idle && ((sel == FETCH_RD) || (sel == NONE)) && slv_arready;
    assign data_arready  = idle && (sel == DATA_RD) && slv_arready;
    assign data_awready  = idle && (sel == DATA_WR) && slv_awready;
    assign data_wready   = idle && (sel == DATA_WR) && slv_wready;

    assign addr_fire = (slv_arvalid && slv_arready) || (slv_awvalid && slv_awready);
    assign resp_fire = (slv_rvalid && slv_rready) || (slv_bvalid && slv_bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant_q      <= NONE;
            data_first_q <= 1'b0;
        end else if (idle && addr_fire) begin
            grant_q      <= sel;
            data_first_q <= (sel == FETCH_RD);
        end else if (!idle && resp_fire) begin
            grant_q <= NONE;
        end
    end

    // Responses return only to the granted port.
    assign fetch_r = slv_r;
    assign data_r  = slv_r;
    assign data_b  = slv_b;

    assign fetch_rvalid = (grant_q == FETCH_RD) && slv_rvalid;
    assign data_rvalid  = (grant_q == DATA_RD) && slv_rvalid;
    assign data_bvalid  = (grant_q == DATA_WR) && slv_bvalid;

    always_comb begin
        case (grant_q)
            FETCH_RD: slv_rready = fetch_rready;
            DATA_RD:  slv_rready = data_rready;
            default:  slv_rready = 1'b0;
        endcase
    end

    assign slv_bready = (grant_q == DATA_WR) && data_bready;

endmodule

// ==== source/axi_sram_sys.sv ====
`timescale 1ns/1ps

module axi_sram_sys (
    input  logic                  clk,
    input  logic                  rst,
    input  axi_sram_pkg::axi_ar_t fetch_ar,
    input  logic                  fetch_arvalid,
    output logic                  fetch_arready,
    output axi_sram_pkg::axi_r_t  fetch_r,
    output logic                  fetch_rvalid,
    input  logic                  fetch_rready,
    input  axi_sram_pkg::axi_ar_t data_ar,
    input  logic                  data_arvalid,
    output logic                  data_arready,
    input  axi_sram_pkg::axi_aw_t data_aw,
    input  logic                  data_awvalid,
    output logic                  data_awready,
    input  axi_sram_pkg::axi_w_t  data_w,
    input  logic                  data_wvalid,
    output logic                  data_wready,
    output axi_sram_pkg::axi_b_t  data_b,
    output logic                  data_bvalid,
    input  logic                  data_bready,
    output axi_sram_pkg::axi_r_t  data_r,
    output logic                  data_rvalid,
    input  logic                  data_rready
);
    import axi_sram_pkg::*;

    // Arbiter to slave.
    axi_ar_t slv_ar;
    logic    slv_arvalid;
    logic    slv_arready;
    axi_aw_t slv_aw;
    logic    slv_awvalid;
    logic    slv_awready;
    axi_w_t  slv_w;
    logic    slv_wvalid;
    logic    slv_wready;
    axi_b_t  slv_b;
    logic    slv_bvalid;
    logic    slv_bready;
    axi_r_t  slv_r;
    logic    slv_rvalid;
    logic    slv_rready;

    // Slave to storage.
    logic                  mem_rd_en;
    logic                  mem_wr_en;
    logic [SRAM_IDX_W-1:0] mem_idx;
    logic [31:0]           mem_wdata;
    logic [3:0]            mem_wstrb;
    logic [31:0]           mem_rdata;

    axi_sram_arbiter u_arbiter (.*);

    axi_sram_slave u_slave (.*);

    sram_byte_array u_sram (
        .clk   (clk),
        .rd_en (mem_rd_en),
        .wr_en (mem_wr_en),
        .idx   (mem_idx),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .rdata (mem_rdata)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== testbench/axi_sram_sys_assert.sv ====
`timescale 1ns/1ps

module axi_sram_sys_assert (
    input logic                  clk,
    input logic                  rst,
    input axi_sram_pkg::axi_ar_t fetch_ar,
    input logic                  fetch_arvalid,
    input logic                  fetch_arready,
    input axi_sram_pkg::axi_r_t  fetch_r,
    input logic                  fetch_rvalid,
    input logic                  fetch_rready,
    input axi_sram_pkg::axi_ar_t data_ar,
    input logic                  data_arvalid,
    input logic                  data_arready,
    input axi_sram_pkg::axi_aw_t data_aw,
    input logic                  data_awvalid,
    input logic                  data_awready,
    input axi_sram_pkg::axi_w_t  data_w,
    input logic                  data_wvalid,
    input logic                  data_wready,
    input axi_sram_pkg::axi_b_t  data_b,
    input logic                  data_bvalid,
    input logic                  data_bready,
    input axi_sram_pkg::axi_r_t  data_r,
    input logic                  data_rvalid,
    input logic                  data_rready
);
    import axi_sram_pkg::*;

    int          err_count = 0;
    logic [7:0]  shadow [4096];
    logic [31:0] fetch_addr_q;
    logic [31:0] data_addr_q;
    logic [31:0] wr_addr_q;
    logic [3:0]  fetch_id_q;
    logic [3:0]  data_id_q;
    logic [3:0]  wr_id_q;
    logic        fetch_fire;
    logic        data_fire;
    logic        data_req;
    logic        fetch_wait_q;  // Last grant went to fetch while data waited.
    logic        data_wait_q;

    function automatic logic hit(input logic [31:0] addr);
        return (addr >= 32'h8000_0000) && (addr < 32'h8000_1000);
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [11:0] off;
        off = {addr[11:2], 2'b00};
        return {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 8'h00;
        end
    end

    assign fetch_fire = fetch_arvalid && fetch_arready;
    assign data_fire  = (data_arvalid && data_arready) || (data_awvalid && data_awready);
    assign data_req   = data_arvalid || (data_awvalid && data_wvalid);

    always @(posedge clk) begin
        if (fetch_fire) begin
            fetch_addr_q <= fetch_ar.addr;
            fetch_id_q   <= fetch_ar.id;
        end
        if (data_arvalid && data_arready) begin
            data_addr_q <= data_ar.addr;
            data_id_q   <= data_ar.id;
        end
        if (data_awvalid && data_awready) begin
            wr_addr_q <= data_aw.addr;
            wr_id_q   <= data_aw.id;
            if (hit(data_aw.addr)) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_w.strb[b]) begin
                        shadow[{data_aw.addr[11:2], 2'b00} + b] <= data_w.data[8*b +: 8];
                    end
                end
            end
        end
        if (fetch_fire || data_fire) begin
            fetch_wait_q <= fetch_fire && data_req;
            data_wait_q  <= data_fire && fetch_arvalid;
        end
    end

    initial begin
        fetch_wait_q = 1'b0;
        data_wait_q  = 1'b0;
    end

    a_reset: assert property (@(posedge clk)
        rst |-> !fetch_rvalid && !data_rvalid && !data_bvalid && fetch_arready)
        else begin
            err_count++;
            $error("Response valid or fetch arready wrong while in reset");
        end

    a_fetch_lat: assert property (@(posedge clk) disable iff (rst)
        fetch_fire |=> !fetch_rvalid ##1 fetch_rvalid)
        else begin
            err_count++;
            $error("fetch_rvalid did not rise 2 edges after the AR transfer");
        end

    a_data_lat: assert property (@(posedge clk) disable iff (rst)
        (data_arvalid && data_arready) |=> !data_rvalid ##1 data_rvalid)
        else begin
            err_count++;
            $error("data_rvalid did not rise 2 edges after the AR transfer");
        end

    a_write_lat: assert property (@(posedge clk) disable iff (rst)
        (data_awvalid && data_awready) |=> data_bvalid)
        else begin
            err_count++;
            $error("data_bvalid did not rise 1 edge after the AW/W transfer");
        end

    a_aw_w: assert property (@(posedge clk) disable iff (rst)
        (data_awvalid && data_awready) == (data_wvalid && data_wready))
        else begin
            err_count++;
            $error("AW and W were not accepted in the same cycle");
        end

    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        (fetch_rvalid && !fetch_rready) |=> fetch_rvalid && $stable(fetch_r))
        else begin
            err_count++;
            $error("fetch_r response changed while stalled");
        end

    a_data_hold: assert property (@(posedge clk) disable iff (rst)
        (data_rvalid && !data_rready) |=> data_rvalid && $stable(data_r))
        else begin
            err_count++;
            $error("data_r response changed while stalled");
        end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        (data_bvalid && !data_bready) |=> data_bvalid && $stable(data_b))
        else begin
            err_count++;
            $error("data_b response changed while stalled");
        end

    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        $onehot0({fetch_rvalid, data_rvalid, data_bvalid}))
        else begin
            err_count++;
            $error("More than one port sees a response at once");
        end

    a_fetch_r: assert property (@(posedge clk) disable iff (rst)
        fetch_rvalid |-> fetch_r.id == fetch_id_q && fetch_r.last
            && fetch_r.resp == (hit(fetch_addr_q) ? OKAY : DECERR)
            && fetch_r.data == (hit(fetch_addr_q) ? shadow_word(fetch_addr_q) : 32'h0))
        else begin
            err_count++;
            $error("CHECK FAILED fetch_r got %h exp id %h data %h", $sampled(fetch_r),
                fetch_id_q, hit(fetch_addr_q) ? shadow_word(fetch_addr_q) : 32'h0);
        end

    a_data_r: assert property (@(posedge clk) disable iff (rst)
        data_rvalid |-> data_r.id == data_id_q && data_r.last
            && data_r.resp == (hit(data_addr_q) ? OKAY : DECERR)
            && data_r.data == (hit(data_addr_q) ? shadow_word(data_addr_q) : 32'h0))
        else begin
            err_count++;
            $error("CHECK FAILED data_r got %h exp id %h data %h", $sampled(data_r),
                data_id_q, hit(data_addr_q) ? shadow_word(data_addr_q) : 32'h0);
        end

    a_data_b: assert property (@(posedge clk) disable iff (rst)
        data_bvalid |-> data_b.id == wr_id_q
            && data_b.resp == (hit(wr_addr_q) ? OKAY : DECERR))
        else begin
            err_count++;
            $error("CHECK FAILED data_b got %h exp id %h", $sampled(data_b), wr_id_q);
        end

    a_fair: assert property (@(posedge clk) disable iff (rst)
        !(fetch_fire && data_req && fetch_wait_q) && !(data_fire && fetch_arvalid && data_wait_q))
        else begin
            err_count++;
            $error("A port was granted twice in a row while the other waited");
        end

endmodule

// ==== testbench/tb_axi_sram_sys.sv ====
`timescale 1ns/1ps

module tb_axi_sram_sys;
    import axi_sram_pkg::*;

    localparam int N_FETCH = 60;
    localparam int N_DATA  = 80;
    localparam int N_TRANS = N_FETCH + N_DATA + 4;

    logic    clk;
    logic    rst;
    axi_ar_t fetch_ar;
    logic    fetch_arvalid;
    logic    fetch_arready;
    axi_r_t  fetch_r;
    logic    fetch_rvalid;
    logic    fetch_rready;
    axi_ar_t data_ar;
    logic    data_arvalid;
    logic    data_arready;
    axi_aw_t data_aw;
    logic    data_awvalid;
    logic    data_awready;
    axi_w_t  data_w;
    logic    data_wvalid;
    logic    data_wready;
    axi_b_t  data_b;
    logic    data_bvalid;
    logic    data_bready;
    axi_r_t  data_r;
    logic    data_rvalid;
    logic    data_rready;

    logic        fetch_ar_done;
    logic        fetch_r_done;
    logic        data_ar_done;
    logic        data_aw_done;
    logic        data_r_done;
    logic        data_b_done;
    logic [31:0] lfsr = 32'h0dd4d6a7;

    tb_clock_gen u_clock_gen (.clk(clk), .rst(rst));

    axi_sram_sys u_dut (.*);

    bind axi_sram_sys axi_sram_sys_assert u_assert (.*);

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // Low and high corners of the window, so reads often hit written words.
    function automatic logic [31:0] window_addr();
        logic [9:0] idx;
        idx = {(get_bits(1) != 0) ? 6'h3f : 6'h00, 4'(get_bits(4))};
        return SRAM_BASE + {20'h0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] outside_addr();
        case (get_bits(2))
            0:       return 32'h8000_1000;
            1:       return 32'h7fff_fffc;
            2:       return 32'h0000_0010;
            default: return 32'hffff_fff0;
        endcase
    endfunction

    always @(posedge clk) begin
        fetch_ar_done <= fetch_arvalid && fetch_arready;
        fetch_r_done  <= fetch_rvalid && fetch_rready;
        data_ar_done  <= data_arvalid && data_arready;
        data_aw_done  <= data_awvalid && data_awready;
        data_r_done   <= data_rvalid && data_rready;
        data_b_done   <= data_bvalid && data_bready;
    end

    // Each task starts and ends on a falling edge, so requests run back to back.
    task automatic fetch_read(input logic [31:0] addr);
        fetch_ar      = '{addr: addr, id: 4'(get_bits(4)), len: 8'd0, size: 3'd2, burst: 2'b01};
        fetch_arvalid = 1'b1;
        do @(negedge clk); while (!fetch_ar_done);
        fetch_arvalid = 1'b0;
        while (!fetch_r_done) begin
            fetch_rready = get_bits(1) != 0;  // Random stall.
            @(negedge clk);
        end
        fetch_rready = 1'b0;
    endtask

    task automatic data_read(input logic [31:0] addr);
        data_ar      = '{addr: addr, id: 4'(get_bits(4)), len: 8'd0, size: 3'd2, burst: 2'b01};
        data_arvalid = 1'b1;
        do @(negedge clk); while (!data_ar_done);
        data_arvalid = 1'b0;
        while (!data_r_done) begin
            data_rready = get_bits(1) != 0;
            @(negedge clk);
        end
        data_rready = 1'b0;
    endtask

    task automatic data_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb);
        data_aw      = '{addr: addr, id: 4'(get_bits(4)), len: 8'd0, size: 3'd2, burst: 2'b01};
        data_w       = '{data: wdata, strb: strb, last: 1'b1};
        data_awvalid = 1'b1;
        data_wvalid  = 1'b1;
        do @(negedge clk); while (!data_aw_done);
        data_awvalid = 1'b0;
        data_wvalid  = 1'b0;
        while (!data_b_done) begin
            data_bready = get_bits(1) != 0;
            @(negedge clk);
        end
        data_bready = 1'b0;
    endtask

    // Stop at the first assertion failure.
    always @(posedge clk) begin
        if (u_dut.u_assert.err_count != 0) begin
            $display("TEST FAILED");
            $fatal(1, "Assertion failure, run stopped");
        end
    end

    initial begin
        #(N_TRANS * 40 * 40);
        $display("Watchdog timeout, the transactions did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "Run stopped by watchdog");
    end

    initial begin
        fetch_ar      = '0;
        fetch_arvalid = 1'b0;
        fetch_rready  = 1'b0;
        data_ar       = '0;
        data_arvalid  = 1'b0;
        data_aw       = '0;
        data_awvalid  = 1'b0;
        data_w        = '0;
        data_wvalid   = 1'b0;
        data_bready   = 1'b0;
        data_rready   = 1'b0;

        @(negedge rst);

        // Partial strobes, then read back from both ports.
        data_write(SRAM_BASE + 32'h10, 32'h1122_3344, 4'hf);
        data_write(SRAM_BASE + 32'h10, 32'haabb_ccdd, 4'b0101);
        fetch_read(SRAM_BASE + 32'h10);
        data_read(SRAM_BASE + 32'h10);

        fork
            begin
                for (int i = 0; i < N_FETCH; i++) begin
                    fetch_read((get_bits(3) == 0) ? outside_addr() : window_addr());
                end
            end
            begin
                for (int i = 0; i < N_DATA; i++) begin
                    case (get_bits(2))
                        0, 1:    data_write(window_addr(), get_bits(32), 4'(get_bits(4)));
                        2:       data_read(window_addr());
                        default: begin
                            if (get_bits(1) != 0) begin
                                data_write(outside_addr(), get_bits(32), 4'hf);
                            end else begin
                                data_read(outside_addr());
                            end
                        end
                    endcase
                end
            end
        join

        repeat (4) @(negedge clk);
        if (u_dut.u_assert.err_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Assertion failures were seen");
        end
    end

endmodule

// ==== axi_sram_sys.f ====
source/axi_sram_pkg.sv
source/sram_byte_array.sv
source/axi_sram_slave.sv
source/axi_sram_arbiter.sv
source/axi_sram_sys.sv
testbench/tb_clock_gen.sv
testbench/axi_sram_sys_assert.sv
testbench/tb_axi_sram_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI SRAM subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_axi_sram_sys \
    -f axi_sram_sys.f \
    -o sim_axi_sram_sys

# Assertion errors keep the run going so the testbench can report them itself.
./obj_dir/sim_axi_sram_sys +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
